//--- src/isa_pkg.sv
package isa_pkg;

    // ******************************
    // opcodes and function fields
    // ******************************
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101; // funct7 picks srl or sra.
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [6:0] F7_ALT = 7'b0100000;

    localparam int NUM_REGS = 32;

    typedef logic [4:0] reg_idx_t;

    // ******************************
    // instruction word views
    // ******************************
    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        u_fmt_t u_fmt;
    } instr_u;

endpackage

//--- src/alu_pkg.sv
package alu_pkg;

    localparam int SHAMT_W = 5;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_op_e;

    typedef struct packed {
        alu_op_e           alu_op;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
        logic              use_imm;
        logic [31:0]       imm;       // already sign or zero extended.
        logic              zero_s1;   // forces operand a to zero for lui.
        logic              writes_rd;
        logic              is_branch;
        logic [2:0]        br_cond;
        logic              legal;
    } decoded_t;

    typedef struct packed {
        logic lt;
        logic ltu;
        logic eq;
    } flags_t;

    typedef struct packed {
        logic              valid;
        isa_pkg::reg_idx_t rd;
        logic [31:0]       data;
    } wb_t;

    typedef struct packed {
        logic valid;
        logic taken;
    } branch_t;

endpackage

//--- src/exec_decoder.sv
`timescale 1ns/1ps

module exec_decoder (
    input  isa_pkg::instr_u   I_instr,
    output alu_pkg::decoded_t O_dec
);
    import isa_pkg::*;
    import alu_pkg::*;

    logic [2:0] f3;
    logic [6:0] f7;
    logic [6:0] sh_f7;

    assign f3    = I_instr.i_fmt.funct3;
    assign f7    = I_instr.r_fmt.funct7;
    assign sh_f7 = I_instr.i_fmt.imm12[11:5]; // upper immediate bits act as funct7 for shifts.

    function automatic alu_op_e op_from_f3(input logic [2:0] funct3);
        alu_op_e op;
        case (funct3)
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    always_comb begin
        O_dec         = '0;
        O_dec.alu_op  = ALU_ADD;
        O_dec.rs1     = I_instr.r_fmt.rs1;
        O_dec.rs2     = I_instr.r_fmt.rs2;
        O_dec.rd      = I_instr.r_fmt.rd;
        O_dec.br_cond = I_instr.r_fmt.funct3;

        case (I_instr.r_fmt.opcode)
            OPC_OP: begin
                O_dec.writes_rd = 1'b1;
                O_dec.alu_op    = op_from_f3(f3);
                O_dec.legal     = (f7 == 7'd0) ||
                                  ((f7 == F7_ALT) && ((f3 == F3_ADD) || (f3 == F3_SR)));
                if (f7 == F7_ALT) begin
                    O_dec.alu_op = (f3 == F3_ADD) ? ALU_SUB : ALU_SRA;
                end
            end
            OPC_OP_IMM: begin
                O_dec.writes_rd = 1'b1;
                O_dec.use_imm   = 1'b1;
                O_dec.legal     = 1'b1;
                O_dec.alu_op    = op_from_f3(f3);
                O_dec.imm       = {{20{I_instr.i_fmt.imm12[11]}}, I_instr.i_fmt.imm12};
                if ((f3 == F3_SLL) || (f3 == F3_SR)) begin
                    O_dec.imm   = {27'd0, I_instr.i_fmt.imm12[4:0]};
                    O_dec.legal = (sh_f7 == 7'd0) || ((f3 == F3_SR) && (sh_f7 == F7_ALT));
                    if (sh_f7 == F7_ALT) begin
                        O_dec.alu_op = ALU_SRA;
                    end
                end
            end
            OPC_LUI: begin
                O_dec.writes_rd = 1'b1;
                O_dec.use_imm   = 1'b1;
                O_dec.zero_s1   = 1'b1;
                O_dec.legal     = 1'b1;
                O_dec.rd        = I_instr.u_fmt.rd;
                O_dec.imm       = {I_instr.u_fmt.imm20, 12'd0};
            end
            OPC_BRANCH: begin
                O_dec.is_branch = 1'b1;
                O_dec.alu_op    = ALU_SUB; // only the compare flags are used.
                O_dec.legal     = (f3 != 3'b010) && (f3 != 3'b011);
            end
            default: begin
                O_dec.legal = 1'b0;
            end
        endcase
    end

endmodule

//--- src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic              I_clk,
    input  isa_pkg::reg_idx_t I_rs1,
    input  isa_pkg::reg_idx_t I_rs2,
    output logic [31:0]       O_rdata1,
    output logic [31:0]       O_rdata2,
    input  logic              I_we,
    input  isa_pkg::reg_idx_t I_rd,
    input  logic [31:0]       I_wdata
);
    import isa_pkg::*;

    logic [31:0] regs [NUM_REGS];

    always_ff @(posedge I_clk) begin
        if (I_we && (I_rd != '0)) begin
            regs[I_rd] <= I_wdata; // x0 is never stored.
        end
    end

    always_ff @(posedge I_clk) begin
        if (I_rs1 == '0) begin
            O_rdata1 <= 32'd0;
        end else begin
            O_rdata1 <= regs[I_rs1];
        end
        if (I_rs2 == '0) begin
            O_rdata2 <= 32'd0;
        end else begin
            O_rdata2 <= regs[I_rs2];
        end
    end

endmodule

//--- src/exec_alu.sv
`timescale 1ns/1ps

module exec_alu (
    input  logic             I_clk,
    input  logic             I_reset,
    input  logic             I_en,
    input  alu_pkg::alu_op_e I_op,
    input  logic [31:0]      I_a,
    input  logic [31:0]      I_b,
    output logic             O_busy,
    output logic [31:0]      O_data,
    output alu_pkg::flags_t  O_flags
);
    import alu_pkg::*;

    logic [31:0]        sum;
    logic [32:0]        diff; // top bit is the borrow.
    logic [31:0]        and_v;
    logic [31:0]        or_v;
    logic [31:0]        xor_v;
    logic               lt;
    logic               ltu;
    logic               eq;
    logic               busy_q;
    logic [SHAMT_W-1:0] cnt_q;
    logic [31:0]        result_q;
    flags_t             flags_q;

    assign O_busy  = busy_q;
    assign O_data  = result_q;
    assign O_flags = flags_q;

    always_comb begin
        sum   = I_a + I_b;
        diff  = {1'b0, I_a} - {1'b0, I_b};
        and_v = I_a & I_b;
        or_v  = I_a | I_b;
        xor_v = I_a ^ I_b;
        ltu   = diff[32];
        lt    = diff[32] ^ xor_v[31]; // sign bits differ flips the borrow meaning.
        eq    = (diff == 33'd0);
    end

    // ******************************
    // result, flags and serial shifter
    // ******************************
    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            busy_q <= 1'b0;
        end else if (I_en) begin
            case (I_op)
                ALU_SUB:  result_q <= diff[31:0];
                ALU_AND:  result_q <= and_v;
                ALU_OR:   result_q <= or_v;
                ALU_XOR:  result_q <= xor_v;
                ALU_SLT:  result_q <= {31'd0, lt};
                ALU_SLTU: result_q <= {31'd0, ltu};
                ALU_SLL, ALU_SRL, ALU_SRA: begin
                    if (!busy_q) begin
                        busy_q   <= 1'b1;
                        result_q <= I_a;
                        cnt_q    <= I_b[SHAMT_W-1:0];
                    end else if (cnt_q != '0) begin
                        case (I_op)
                            ALU_SLL: result_q <= {result_q[30:0], 1'b0};
                            ALU_SRL: result_q <= {1'b0, result_q[31:1]};
                            default: result_q <= {result_q[31], result_q[31:1]};
                        endcase
                        cnt_q <= cnt_q - 1'b1; // one bit per cycle.
                    end else begin
                        busy_q <= 1'b0;
                    end
                end
                default:  result_q <= sum;
            endcase

            flags_q.lt  <= lt;
            flags_q.ltu <= ltu;
            flags_q.eq  <= eq;
        end
    end

endmodule

//--- src/exec_sequencer.sv
`timescale 1ns/1ps

module exec_sequencer (
    input  logic              I_clk,
    input  logic              I_reset,
    input  logic              I_instr_valid,
    input  isa_pkg::instr_u   I_instr,
    output isa_pkg::instr_u   O_instr_q,
    input  alu_pkg::decoded_t I_dec,
    output logic              O_alu_en,
    input  logic              I_alu_busy,
    input  logic [31:0]       I_alu_data,
    input  alu_pkg::flags_t   I_flags,
    output logic              O_we,
    output logic              O_busy,
    output alu_pkg::wb_t      O_wb,
    output alu_pkg::branch_t  O_branch,
    output logic              O_fault
);
    import isa_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_READ, ST_EXEC, ST_RETIRE} state_e;

    state_e state;
    logic   started;   // set once the first enabled alu edge has passed.
    logic   fault_q;
    logic   accept;
    logic   exec_done;
    logic   taken;

    assign accept    = I_instr_valid && !O_busy;
    assign exec_done = (state == ST_EXEC) && started && !I_alu_busy;
    assign O_alu_en  = (state == ST_EXEC) && !exec_done; // dropped before a shift can reload.
    assign O_we      = exec_done && I_dec.writes_rd;
    assign O_busy    = (state == ST_READ) || (state == ST_EXEC);
    assign O_fault   = fault_q;

    always_ff @(posedge I_clk) begin
        if (I_reset) begin
            state   <= ST_IDLE;
            started <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            fault_q <= 1'b0;
            case (state)
                ST_READ: begin
                    started <= 1'b0;
                    if (I_dec.legal) begin
                        state <= ST_EXEC;
                    end else begin
                        state   <= ST_IDLE;
                        fault_q <= 1'b1;
                    end
                end
                ST_EXEC: begin
                    started <= 1'b1;
                    if (exec_done) begin
                        state <= ST_RETIRE;
                    end
                end
                default: begin
                    state <= accept ? ST_READ : ST_IDLE; // retire also accepts a new word.
                end
            endcase
        end
    end

    always_ff @(posedge I_clk) begin
        if (accept) begin
            O_instr_q <= I_instr;
        end
    end

    always_comb begin
        case (I_dec.br_cond)
            F3_BEQ:  taken = I_flags.eq;
            F3_BNE:  taken = !I_flags.eq;
            F3_BLT:  taken = I_flags.lt;
            F3_BGE:  taken = !I_flags.lt;
            F3_BLTU: taken = I_flags.ltu;
            F3_BGEU: taken = !I_flags.ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        O_wb.valid     = (state == ST_RETIRE) && I_dec.writes_rd;
        O_wb.rd        = I_dec.rd;
        O_wb.data      = I_alu_data;
        O_branch.valid = (state == ST_RETIRE) && I_dec.is_branch;
        O_branch.taken = taken;
    end

endmodule

//--- src/exec_unit_top.sv
`timescale 1ns/1ps

module exec_unit_top (
    input  logic             I_clk,
    input  logic             I_reset,
    input  logic             I_instr_valid,
    input  isa_pkg::instr_u  I_instr,
    output logic             O_busy,
    output alu_pkg::wb_t     O_wb,
    output alu_pkg::branch_t O_branch,
    output logic             O_fault
);
    import isa_pkg::*;
    import alu_pkg::*;

    instr_u      instr_q;
    decoded_t    dec;
    logic [31:0] rdata1;
    logic [31:0] rdata2;
    logic [31:0] alu_a;
    logic [31:0] alu_b;
    logic [31:0] alu_data;
    logic        alu_en;
    logic        alu_busy;
    logic        we;
    flags_t      flags;

    assign alu_a = dec.zero_s1 ? 32'd0 : rdata1;   // lui adds the immediate to zero.
    assign alu_b = dec.use_imm ? dec.imm : rdata2;

    exec_decoder u_decoder (
        .I_instr (instr_q),
        .O_dec   (dec)
    );

    reg_file u_reg_file (
        .I_clk    (I_clk),
        .I_rs1    (dec.rs1),
        .I_rs2    (dec.rs2),
        .O_rdata1 (rdata1),
        .O_rdata2 (rdata2),
        .I_we     (we),
        .I_rd     (dec.rd),
        .I_wdata  (alu_data)
    );

    exec_alu u_alu (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .I_en    (alu_en),
        .I_op    (dec.alu_op),
        .I_a     (alu_a),
        .I_b     (alu_b),
        .O_busy  (alu_busy),
        .O_data  (alu_data),
        .O_flags (flags)
    );

    exec_sequencer u_sequencer (
        .I_clk         (I_clk),
        .I_reset       (I_reset),
        .I_instr_valid (I_instr_valid),
        .I_instr       (I_instr),
        .O_instr_q     (instr_q),
        .I_dec         (dec),
        .O_alu_en      (alu_en),
        .I_alu_busy    (alu_busy),
        .I_alu_data    (alu_data),
        .I_flags       (flags),
        .O_we          (we),
        .O_busy        (O_busy),
        .O_wb          (O_wb),
        .O_branch      (O_branch),
        .O_fault       (O_fault)
    );

endmodule

//--- bench/exec_unit_sva.sv
`timescale 1ns/1ps

module exec_unit_sva (
    input logic             I_clk,
    input logic             I_reset,
    input logic             busy,
    input alu_pkg::wb_t     wb,
    input alu_pkg::branch_t branch,
    input logic             fault
);
    int   fail_count = 0;
    logic any_pulse;

    assign any_pulse = wb.valid || branch.valid || fault;

    // ******************************
    // result pulse rules
    // ******************************
    a_one_kind: assert property (@(posedge I_clk) disable iff (I_reset)
        !(wb.valid && branch.valid))
        else begin
            $error("write-back and branch pulses overlap");
            fail_count++;
        end

    a_wb_pulse: assert property (@(posedge I_clk) disable iff (I_reset)
        wb.valid |=> !wb.valid)
        else begin
            $error("write-back pulse longer than one cycle");
            fail_count++;
        end

    a_br_pulse: assert property (@(posedge I_clk) disable iff (I_reset)
        branch.valid |=> !branch.valid)
        else begin
            $error("branch pulse longer than one cycle");
            fail_count++;
        end

    a_fault_pulse: assert property (@(posedge I_clk) disable iff (I_reset)
        fault |=> !fault)
        else begin
            $error("fault pulse longer than one cycle");
            fail_count++;
        end

    a_idle_after: assert property (@(posedge I_clk) disable iff (I_reset)
        any_pulse |=> !busy) // nothing new is in flight right after a pulse.
        else begin
            $error("unit busy in the cycle after a result or fault");
            fail_count++;
        end

endmodule

//--- bench/exec_unit_tb.sv
`timescale 1ns/1ps

module exec_unit_tb;
    import isa_pkg::*;
    import alu_pkg::*;

    localparam int         RESP_LIMIT = 45;
    localparam logic [1:0] M_FIX      = 2'd0;
    localparam logic [1:0] M_RND      = 2'd1;
    localparam logic [1:0] M_RND_A    = 2'd2; // random a, fixed b.
    localparam logic [2:0] BR_F3 [6]  = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

    typedef enum logic [2:0] {K_R, K_I, K_LUI, K_BR, K_ILL, K_BUSY} kind_e;

    typedef struct packed {
        kind_e       kind;
        logic [6:0]  f7;    // funct7, or the raw opcode of an illegal row.
        logic [2:0]  f3;
        reg_idx_t    rd;
        reg_idx_t    rb;    // register read back after the instruction.
        logic [19:0] imm;
        logic [1:0]  mode;
        logic [31:0] a;
        logic [31:0] b;
    } row_t;

    logic        I_clk;
    logic        I_reset;
    logic        instr_valid;
    instr_u      instr;
    logic        busy;
    wb_t         wb;
    branch_t     br;
    logic        fault;
    row_t        rows [$];
    string       names [$];
    string       cur_name;
    logic [31:0] rng;
    int          errors      = 0;
    int          cycles      = 0;
    int          cycle_limit = 0;

    exec_unit_top dut (
        .I_clk         (I_clk),
        .I_reset       (I_reset),
        .I_instr_valid (instr_valid),
        .I_instr       (instr),
        .O_busy        (busy),
        .O_wb          (wb),
        .O_branch      (br),
        .O_fault       (fault)
    );

    bind exec_unit_top exec_unit_sva u_sva (
        .I_clk   (I_clk),
        .I_reset (I_reset),
        .busy    (O_busy),
        .wb      (O_wb),
        .branch  (O_branch),
        .fault   (O_fault)
    );

    initial begin
        I_clk = 1'b0;
        forever #50 I_clk = ~I_clk;
    end

    always @(posedge I_clk) begin
        cycles <= cycles + 1;
        if ((cycle_limit > 0) && (cycles >= cycle_limit)) begin
            $display("Error: run stopped after %0d cycles without finishing", cycles);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // ******************************
    // encoding and reference model
    // ******************************
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic instr_u enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                     input reg_idx_t rs1, input logic [2:0] f3,
                                     input reg_idx_t rd, input logic [6:0] opc);
        instr_u w;
        w.r_fmt = '{f7, rs2, rs1, f3, rd, opc};
        return w;
    endfunction

    function automatic instr_u enc_i(input logic [11:0] imm12, input reg_idx_t rs1,
                                     input logic [2:0] f3, input reg_idx_t rd);
        instr_u w;
        w.i_fmt = '{imm12, rs1, f3, rd, OPC_OP_IMM};
        return w;
    endfunction

    function automatic instr_u enc_u(input logic [19:0] imm20, input reg_idx_t rd);
        instr_u w;
        w.u_fmt = '{imm20, rd, OPC_LUI};
        return w;
    endfunction

    function automatic logic [31:0] model_alu(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            F3_ADD:  r = alt ? (a - b) : (a + b);
            F3_SLL:  r = a << b[4:0];
            F3_SLT:  r = {31'd0, $signed(a) < $signed(b)};
            F3_SLTU: r = {31'd0, a < b};
            F3_XOR:  r = a ^ b;
            F3_OR:   r = a | b;
            F3_AND:  r = a & b;
            default: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0]; // arithmetic shift keeps the sign.
                end else begin
                    r = a >> b[4:0];
                end
            end
        endcase
        return r;
    endfunction

    function automatic logic model_branch(input logic [2:0] f3, input logic [31:0] a,
                                          input logic [31:0] b);
        logic t;
        case (f3)
            F3_BEQ:  t = (a == b);
            F3_BNE:  t = (a != b);
            F3_BLT:  t = ($signed(a) < $signed(b));
            F3_BGE:  t = ($signed(a) >= $signed(b));
            F3_BLTU: t = (a < b);
            default: t = (a >= b);
        endcase
        return t;
    endfunction

    function automatic string branch_name(input logic [2:0] f3);
        case (f3)
            F3_BEQ:  return "beq";
            F3_BNE:  return "bne";
            F3_BLT:  return "blt";
            F3_BGE:  return "bge";
            F3_BLTU: return "bltu";
            default: return "bgeu";
        endcase
    endfunction

    task automatic add_row(input string name, input kind_e kind, input logic [6:0] f7,
                           input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rb,
                           input logic [19:0] imm, input logic [1:0] mode,
                           input logic [31:0] a, input logic [31:0] b);
        row_t r;
        r = '{kind, f7, f3, rd, rb, imm, mode, a, b};
        rows.push_back(r);
        names.push_back(name);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s %s: got 0x%08h, expected 0x%08h", cur_name, what, got, exp);
            errors++;
        end
    endtask

    // ******************************
    // instruction issue
    // ******************************
    task automatic issue(input instr_u word, input logic stray, output wb_t got_wb,
                         output branch_t got_br, output logic got_fault, output int edges);
        int   n;
        logic seen;
        n         = 0;
        seen      = 1'b0;
        got_wb    = '0;
        got_br    = '0;
        got_fault = 1'b0;
        edges     = -1;
        @(negedge I_clk);
        while (busy) @(negedge I_clk);
        instr       = word;
        instr_valid = 1'b1;
        while (!seen && (n < RESP_LIMIT)) begin
            @(negedge I_clk);
            instr_valid = stray && (n == 1); // lands while the unit is busy.
            if (stray && (n == 1)) begin
                instr = enc_i(12'h7ff, 5'd0, F3_ADD, 5'd1);
            end
            if (wb.valid || br.valid || fault) begin
                check_value("O_busy", 32'(busy), 32'd0);
                got_wb    = wb;
                got_br    = br;
                got_fault = fault;
                edges     = n;
                seen      = 1'b1;
            end else begin
                check_value("O_busy", 32'(busy), 32'd1);
                n++;
            end
        end
        instr_valid = 1'b0;
        if (!seen) begin
            $display("Error: %s got no result or fault pulse within %0d cycles",
                     cur_name, RESP_LIMIT);
            errors++;
        end
    endtask

    task automatic load_reg(input reg_idx_t r, input logic [31:0] v);
        logic [19:0] hi;
        wb_t         w;
        branch_t     b;
        logic        f;
        int          n;
        hi = v[31:12] + {19'd0, v[11]}; // addi sign extends its low part.
        issue(enc_u(hi, r), 1'b0, w, b, f, n);
        issue(enc_i(v[11:0], r, F3_ADD, r), 1'b0, w, b, f, n);
        check_value("operand load O_wb.data", w.data, v);
    endtask

    // ******************************
    // test table and main loop
    // ******************************
    initial begin
        row_t        row;
        instr_u      word;
        wb_t         got_wb;
        branch_t     got_br;
        logic        got_fault;
        int          n;
        int          errs_before;
        int          passed;
        int          sva_fails;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_x;
        logic [31:0] exp_data;
        logic [31:0] exp_rb;
        logic        alt;
        logic        shift;
        logic        writes;

        I_reset     = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        rng         = 32'd81517;
        passed      = 0;

        add_row("add", K_R, 7'h00, F3_ADD, 5'd3, 5'd3, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("sub", K_R, F7_ALT, F3_ADD, 5'd4, 5'd4, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("and", K_R, 7'h00, F3_AND, 5'd5, 5'd5, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("or", K_R, 7'h00, F3_OR, 5'd6, 5'd6, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("xor", K_R, 7'h00, F3_XOR, 5'd3, 5'd3, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("slt", K_R, 7'h00, F3_SLT, 5'd4, 5'd4, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("sltu", K_R, 7'h00, F3_SLTU, 5'd5, 5'd5, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("slt_sign", K_R, 7'h00, F3_SLT, 5'd6, 5'd6, 20'h0, M_FIX, 32'hffff_fff0, 32'h10);
        add_row("sltu_sign", K_R, 7'h00, F3_SLTU, 5'd3, 5'd3, 20'h0, M_FIX, 32'hffff_fff0, 32'h10);
        add_row("addi", K_I, 7'h00, F3_ADD, 5'd4, 5'd4, 20'h007ff, M_RND, 32'h0, 32'h0);
        add_row("addi_neg", K_I, 7'h00, F3_ADD, 5'd5, 5'd5, 20'h00800, M_RND, 32'h0, 32'h0);
        add_row("slti", K_I, 7'h00, F3_SLT, 5'd6, 5'd6, 20'h00fff, M_RND, 32'h0, 32'h0);
        add_row("sltiu", K_I, 7'h00, F3_SLTU, 5'd3, 5'd3, 20'h00fff, M_RND, 32'h0, 32'h0);
        add_row("xori", K_I, 7'h00, F3_XOR, 5'd4, 5'd4, 20'h00555, M_RND, 32'h0, 32'h0);
        add_row("ori", K_I, 7'h00, F3_OR, 5'd5, 5'd5, 20'h000f0, M_RND, 32'h0, 32'h0);
        add_row("andi", K_I, 7'h00, F3_AND, 5'd6, 5'd6, 20'h00f0f, M_RND, 32'h0, 32'h0);
        add_row("lui", K_LUI, 7'h00, 3'd0, 5'd3, 5'd3, 20'habcde, M_FIX, 32'h0, 32'h0);
        add_row("lui_top", K_LUI, 7'h00, 3'd0, 5'd4, 5'd4, 20'h80000, M_FIX, 32'h0, 32'h0);
        add_row("addi_x0", K_I, 7'h00, F3_ADD, 5'd0, 5'd0, 20'h00123, M_RND, 32'h0, 32'h0);
        add_row("sll_0", K_R, 7'h00, F3_SLL, 5'd5, 5'd5, 20'h0, M_RND_A, 32'h0, 32'd0);
        add_row("sll_1", K_R, 7'h00, F3_SLL, 5'd6, 5'd6, 20'h0, M_RND_A, 32'h0, 32'd1);
        add_row("sll_31", K_R, 7'h00, F3_SLL, 5'd3, 5'd3, 20'h0, M_RND_A, 32'h0, 32'd31);
        add_row("sll_rnd", K_R, 7'h00, F3_SLL, 5'd4, 5'd4, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("srl_1", K_R, 7'h00, F3_SR, 5'd5, 5'd5, 20'h0, M_RND_A, 32'h0, 32'd1);
        add_row("srl_31", K_R, 7'h00, F3_SR, 5'd6, 5'd6, 20'h0, M_RND_A, 32'h0, 32'd31);
        add_row("srl_rnd", K_R, 7'h00, F3_SR, 5'd3, 5'd3, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("sra_31", K_R, F7_ALT, F3_SR, 5'd4, 5'd4, 20'h0, M_FIX, 32'h8000_0000, 32'd31);
        add_row("sra_rnd", K_R, F7_ALT, F3_SR, 5'd5, 5'd5, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("slli_31", K_I, 7'h00, F3_SLL, 5'd6, 5'd6, 20'h0001f, M_RND, 32'h0, 32'h0);
        add_row("srli_0", K_I, 7'h00, F3_SR, 5'd3, 5'd3, 20'h00000, M_RND, 32'h0, 32'h0);
        add_row("srai_7", K_I, 7'h00, F3_SR, 5'd4, 5'd4, 20'h00407, M_RND, 32'h0, 32'h0);
        for (int k = 0; k < 6; k++) begin
            add_row({branch_name(BR_F3[k]), "_eq"}, K_BR, 7'h00, BR_F3[k], 5'd0, 5'd0,
                    20'h0, M_FIX, 32'h8000_0001, 32'h8000_0001);
            add_row({branch_name(BR_F3[k]), "_sign"}, K_BR, 7'h00, BR_F3[k], 5'd0, 5'd0,
                    20'h0, M_FIX, 32'hffff_fff0, 32'h10);
            add_row({branch_name(BR_F3[k]), "_rnd"}, K_BR, 7'h00, BR_F3[k], 5'd0, 5'd0,
                    20'h0, M_RND, 32'h0, 32'h0);
        end
        add_row("illegal", K_ILL, 7'b0000011, 3'd0, 5'd1, 5'd1, 20'h0, M_RND, 32'h0, 32'h0);
        add_row("busy_strobe", K_BUSY, 7'h00, F3_SLL, 5'd3, 5'd1, 20'h0, M_RND_A, 32'h0, 32'd20);

        cycle_limit = rows.size() * 3 * 45;
        repeat (10) @(negedge I_clk);
        I_reset = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            row         = rows[i];
            cur_name    = names[i];
            errs_before = errors;
            a           = row.a;
            b           = row.b;
            if (row.mode != M_FIX) begin
                rng = xorshift32(rng);
                a   = rng;
            end
            if (row.mode == M_RND) begin
                rng = xorshift32(rng);
                b   = rng;
            end
            load_reg(5'd1, a);
            load_reg(5'd2, b);

            alt      = 1'b0;
            shift    = 1'b0;
            exp_data = 32'd0;
            writes   = (row.kind != K_BR) && (row.kind != K_ILL);
            case (row.kind)
                K_I: begin
                    word     = enc_i(row.imm[11:0], 5'd1, row.f3, row.rd);
                    imm_x    = {{20{row.imm[11]}}, row.imm[11:0]};
                    alt      = (row.f3 == F3_SR) && (row.imm[11:5] == F7_ALT);
                    shift    = (row.f3 == F3_SLL) || (row.f3 == F3_SR);
                    exp_data = model_alu(row.f3, alt, a, imm_x);
                end
                K_LUI: begin
                    word     = enc_u(row.imm, row.rd);
                    exp_data = {row.imm, 12'd0};
                end
                K_BR: begin
                    word = enc_r(7'h00, 5'd2, 5'd1, row.f3, 5'd0, OPC_BRANCH);
                end
                K_ILL: begin
                    word = enc_r(7'h00, 5'd2, 5'd1, 3'd0, row.rd, row.f7);
                end
                default: begin
                    word     = enc_r(row.f7, 5'd2, 5'd1, row.f3, row.rd, OPC_OP);
                    alt      = (row.f7 == F7_ALT);
                    shift    = (row.f3 == F3_SLL) || (row.f3 == F3_SR);
                    exp_data = model_alu(row.f3, alt, a, b);
                end
            endcase

            issue(word, row.kind == K_BUSY, got_wb, got_br, got_fault, n);
            check_value("O_fault", 32'(got_fault), 32'(row.kind == K_ILL));
            check_value("O_branch.valid", 32'(got_br.valid), 32'(row.kind == K_BR));
            check_value("O_wb.valid", 32'(got_wb.valid), 32'(writes));
            if (row.kind == K_BR) begin
                check_value("O_branch.taken", 32'(got_br.taken),
                            32'(model_branch(row.f3, a, b)));
            end
            if (writes) begin
                check_value("O_wb.rd", 32'(got_wb.rd), 32'(row.rd));
                check_value("O_wb.data", got_wb.data, exp_data);
                if (!shift) begin
                    check_value("O_wb.valid edge", 32'(n), 32'd3); // fixed alu latency.
                end
            end
            if (row.kind == K_ILL) begin
                check_value("O_fault edge", 32'(n), 32'd1);
            end

            if (row.kind != K_BR) begin
                if (row.rb == 5'd0) begin
                    exp_rb = 32'd0;
                end else if (writes && (row.rb == row.rd)) begin
                    exp_rb = exp_data;
                end else if (row.rb == 5'd1) begin
                    exp_rb = a;
                end else begin
                    exp_rb = b;
                end
                issue(enc_r(7'h00, 5'd0, row.rb, F3_ADD, 5'd7, OPC_OP), 1'b0,
                      got_wb, got_br, got_fault, n);
                check_value("readback O_wb.data", got_wb.data, exp_rb);
            end

            if (errors == errs_before) begin
                passed++;
            end
            $display("test %0d %s: %s", i, cur_name, (errors == errs_before) ? "ok" : "mismatch");
        end

        sva_fails = dut.u_sva.fail_count;
        $display("%0d tests, %0d passed, %0d failed, %0d value errors, %0d assertion failures",
                 rows.size(), passed, rows.size() - passed, errors, sva_fails);
        if ((errors == 0) && (sva_fails == 0)) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- files.f
src/isa_pkg.sv
src/alu_pkg.sv
src/exec_decoder.sv
src/reg_file.sv
src/exec_alu.sv
src/exec_sequencer.sv
src/exec_unit_top.sv
bench/exec_unit_sva.sv
bench/exec_unit_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the execute unit testbench with Verilator, runs it and checks for the pass line.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module exec_unit_tb -f files.f \
    -Mdir obj_dir -o exec_unit_sim || { echo "build failed"; exit 1; }
out=$(./obj_dir/exec_unit_sim +verilator+error+limit+1000)
echo "$out"
echo "$out" | grep -q "^PASS: all tests$" && echo "simulation passed" || { echo "simulation failed"; exit 1; }
